// File: logic/burstGen_config.svh
`ifndef burstGenConfigSvh
`define burstGenConfigSvh

// address walk width in bits
`define burstAddrWidth 16

// width of the beat count minus one
`define burstLenWidth 8

// credits held after reset and the ceiling for returns
`define burstCredits 4
`define burstCreditWidth 3 // wide enough for burstCredits

// prefix tree for every decrementer: 0 serial, 1 brent-kung, 2 sklansky
`define burstSpeed 2

`endif

// File: logic/burstPkg.sv
`include "burstGen_config.svh"

package burstPkg;

	// beat address on the output port
	typedef logic [`burstAddrWidth-1:0] addrT;

	// beats minus one so a zero-length burst cannot be asked for
	typedef logic [`burstLenWidth-1:0] lenT;

	typedef logic [`burstCreditWidth-1:0] creditT; // free downstream slots

	// sequencer states
	typedef enum logic [1:0] {
		stIdle,  // cmdReady up and waiting for a command
		stRun,   // beats issued while credits last
		stDrain  // final beat on the wire and no new command yet
	} burstStateT;

endpackage

// File: logic/PrefixAnd.sv
`timescale 1ns/1ps

module PrefixAnd #(
	parameter int width = 8, // number of propagate bits
	parameter int speed = 2  // 0 serial, 1 brent-kung, 2 sklansky
) (
	input  logic [width-1:0] PI, // propagate in
	output logic [width-1:0] PO  // PO[i] = &PI[i:0]
);

	localparam int depth = $clog2(width); // levels of a log tree

	if (speed == 0 || width == 1) begin : gSerial
		// ripple chain with width-1 gates in a row
		logic [width-1:0] chain;

		assign chain[0] = PI[0];
		for (genvar i = 1; i < width; i++) begin : gBit
			assign chain[i] = chain[i-1] & PI[i];
		end
		assign PO = chain;
	end else if (speed == 1) begin : gBrentKung
		// up-sweep builds group terms at 2^l-1, down-sweep fills the gaps
		logic [width-1:0] pt [0:2*depth-1];

		assign pt[0] = PI;

		for (genvar l = 1; l <= depth; l++) begin : gUp
			for (genvar i = 0; i < width; i++) begin : gBit
				if ((i + 1) % (2**l) == 0) begin : gNode
					// join with the block just below
					assign pt[l][i] = pt[l-1][i] & pt[l-1][i - 2**(l-1)];
				end else begin : gPass
					assign pt[l][i] = pt[l-1][i];
				end
			end
		end

		for (genvar l = depth + 1; l < 2*depth; l++) begin : gDown
			localparam int span = 2**(2*depth - l); // block size on this level

			for (genvar i = 0; i < width; i++) begin : gBit
				if (i >= span && (i + 1) % span == span / 2) begin : gNode
					// mid-block bit takes the finished prefix below its block
					assign pt[l][i] = pt[l-1][i] & pt[l-1][i - span/2];
				end else begin : gPass
					assign pt[l][i] = pt[l-1][i];
				end
			end
		end

		assign PO = pt[2*depth-1];
	end else begin : gSklansky
		// divide and conquer, one level per doubling of the block
		logic [width-1:0] pt [0:depth];

		assign pt[0] = PI;

		for (genvar l = 1; l <= depth; l++) begin : gLevel
			for (genvar i = 0; i < width; i++) begin : gBit
				if ((i / 2**(l-1)) % 2 == 1) begin : gNode
					// upper half of the block picks up the top of the lower half
					assign pt[l][i] = pt[l-1][i]
						& pt[l-1][(i / 2**l) * 2**l + 2**(l-1) - 1];
				end else begin : gPass
					assign pt[l][i] = pt[l-1][i];
				end
			end
		end

		assign PO = pt[depth];
	end

endmodule

// File: logic/DecC.sv
`timescale 1ns/1ps

// {CO, Z} = A - CI built on a prefix AND
module DecC #(
	parameter int width = 8, // operand width
	parameter int speed = 2  // prefix structure, see PrefixAnd
) (
	input  logic [width-1:0] A,  // operand
	input  logic             CI, // borrow in
	output logic [width-1:0] Z,  // difference
	output logic             CO  // borrow out
);

	logic [width:0] prop;      // inverted operand over ci
	logic [width:0] lookahead; // bit i flips when everything below is zero

	// a bit toggles once ci is set and all lower bits of A are zero
	assign prop = {~A, CI};

	PrefixAnd #(
		.width(width + 1),
		.speed(speed)
	) uPrefix (
		.PI(prop),
		.PO(lookahead)
	);

	assign Z  = A ^ lookahead[width-1:0];
	assign CO = lookahead[width]; // A all zero with ci high

endmodule

// File: logic/BeatTimer.sv
`timescale 1ns/1ps
`include "burstGen_config.svh"

module BeatTimer (
	input  logic          clk,
	input  logic          rstN,
	input  logic          load,     // capture a new command
	input  logic          step,     // a beat leaves on this edge
	input  burstPkg::lenT lenM1,    // beats of the command minus one
	output logic          lastBeat  // the beat stepping now is the final one
);

	import burstPkg::*;

	lenT remain;    // beats left behind the next one
	lenT current;   // count that belongs to this cycle's beat
	lenT remainDec;

	// first beat may issue on the accept edge, so look through to lenM1
	assign current = load ? lenM1 : remain;

	// zero count shows up as the borrow, no separate compare
	DecC #(
		.width(`burstLenWidth),
		.speed(`burstSpeed)
	) uDec (
		.A(current),
		.CI(1'b1),
		.Z(remainDec),
		.CO(lastBeat)
	);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			remain <= '0;
		end else if (step) begin
			remain <= remainDec; // covers load and step together
		end else if (load) begin
			remain <= lenM1;     // accepted while out of credits
		end
	end

	// the FSM drains for a cycle after the final beat
	assert property (@(posedge clk) disable iff (!rstN)
		step && lastBeat |=> !step)
		else $error("BeatTimer: beat issued right after the last beat");

endmodule

// File: logic/CreditCounter.sv
`timescale 1ns/1ps
`include "burstGen_config.svh"

module CreditCounter (
	input  logic clk,
	input  logic rstN,
	input  logic step,          // one credit spent on this edge
	input  logic creditReturn,  // one slot freed downstream
	output logic creditAvail    // at least one beat may go
);

	import burstPkg::*;

	creditT count;     // credits on hand
	creditT decIn;
	creditT decOut;
	creditT countNext;

	// increment runs through the same decrementer on the complement
	// since ~(~x - 1) is x + 1
	assign decIn = creditReturn ? ~count : count;

	// ci set for spend only or return only, clear when both cancel
	DecC #(
		.width(`burstCreditWidth),
		.speed(`burstSpeed)
	) uDec (
		.A(decIn),
		.CI(step ^ creditReturn),
		.Z(decOut),
		.CO()
	);

	assign countNext   = creditReturn ? ~decOut : decOut;
	assign creditAvail = |count;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			count <= creditT'(`burstCredits); // full pool
		end else begin
			count <= countNext;
		end
	end

	// downstream never hands back more than it was given
	assert property (@(posedge clk) disable iff (!rstN)
		count <= creditT'(`burstCredits))
		else $error("CreditCounter: credit count above the limit");

	// the FSM must only issue against a credit
	assert property (@(posedge clk) disable iff (!rstN)
		step |-> creditAvail)
		else $error("CreditCounter: beat issued without a credit");

endmodule

// File: logic/AddrWalker.sv
`timescale 1ns/1ps
`include "burstGen_config.svh"

module AddrWalker (
	input  logic           clk,
	input  logic           rstN,
	input  logic           load,  // capture the command base
	input  logic           step,  // a beat leaves on this edge
	input  burstPkg::addrT base,  // first beat address
	output burstPkg::addrT addr   // address of the beat on the wire
);

	import burstPkg::*;

	addrT nextAddr; // address the following beat will carry
	addrT srcAddr;  // address of the beat issued this cycle
	addrT decAddr;

	// base goes straight through when the first beat fires on accept
	assign srcAddr = load ? base : nextAddr;

	// walks down and wraps past zero, borrow not needed
	DecC #(
		.width(`burstAddrWidth),
		.speed(`burstSpeed)
	) uDec (
		.A(srcAddr),
		.CI(1'b1),
		.Z(decAddr),
		.CO()
	);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			addr     <= '0;
			nextAddr <= '0;
		end else if (step) begin
			addr     <= srcAddr;  // held for the beat cycle
			nextAddr <= decAddr;
		end else if (load) begin
			nextAddr <= base;     // accepted with no credit
		end
	end

endmodule

// File: logic/BurstFsm.sv
`timescale 1ns/1ps

module BurstFsm (
	input  logic clk,
	input  logic rstN,
	input  logic cmdValid,
	output logic cmdReady,
	input  logic creditAvail, // a credit is on hand
	input  logic lastBeat,    // beat stepping now ends the burst
	output logic load,        // timer and walker take the command
	output logic step,        // a beat is issued on this edge
	output logic outValid,
	output logic outLast
);

	import burstPkg::*;

	burstStateT state;
	burstStateT stateNext;
	logic       accept;      // command handshake this cycle
	logic       finalStep;   // last beat of the burst goes now

	assign cmdReady = (state == stIdle);
	assign accept   = cmdReady & cmdValid;
	assign load     = accept;

	// first beat can go on the accept edge itself
	assign step      = creditAvail & (accept | (state == stRun));
	assign finalStep = step & lastBeat;

	always_comb begin
		stateNext = state;
		unique case (state)
			stIdle: begin
				if (accept) begin
					stateNext = finalStep ? stDrain : stRun; // single beat skips run
				end
			end
			stRun: begin
				if (finalStep) begin
					stateNext = stDrain;
				end
			end
			stDrain: stateNext = stIdle; // last beat visible for this cycle
			default: stateNext = stIdle;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state    <= stIdle;
			outValid <= 1'b0;
			outLast  <= 1'b0;
		end else begin
			state    <= stateNext;
			outValid <= step;      // beat shows in the cycle after its step
			outLast  <= finalStep;
		end
	end

	// final beat comes with valid, then a quiet cycle before the next command
	assert property (@(posedge clk) disable iff (!rstN)
		outLast |-> outValid ##1 (!outValid && cmdReady))
		else $error("BurstFsm: outLast without valid or no drain after it");

endmodule

// File: logic/burstGen.sv
`timescale 1ns/1ps

module burstGen (
	input  logic           clk,
	input  logic           rstN,
	input  logic           cmdValid,
	input  burstPkg::addrT cmdBase,
	input  burstPkg::lenT  cmdLenM1,
	output logic           cmdReady,
	output logic           outValid,
	output burstPkg::addrT outAddr,
	output logic           outLast,
	input  logic           creditReturn
);

	logic load;        // command capture
	logic step;        // beat issue
	logic lastBeat;    // remaining count hit zero
	logic creditAvail;

	BurstFsm uFsm (
		.clk(clk),
		.rstN(rstN),
		.cmdValid(cmdValid),
		.cmdReady(cmdReady),
		.creditAvail(creditAvail),
		.lastBeat(lastBeat),
		.load(load),
		.step(step),
		.outValid(outValid),
		.outLast(outLast)
	);

	BeatTimer uTimer (
		.clk(clk),
		.rstN(rstN),
		.load(load),
		.step(step),
		.lenM1(cmdLenM1),
		.lastBeat(lastBeat)
	);

	// registered beat address lines up with outValid
	AddrWalker uWalker (
		.clk(clk),
		.rstN(rstN),
		.load(load),
		.step(step),
		.base(cmdBase),
		.addr(outAddr)
	);

	CreditCounter uCredits (
		.clk(clk),
		.rstN(rstN),
		.step(step),
		.creditReturn(creditReturn),
		.creditAvail(creditAvail)
	);

endmodule

// File: tb/tbBurstGen.sv
`timescale 1ns/1ps
`include "burstGen_config.svh"

module tbBurstGen;

	import burstPkg::*;

	localparam int totalBeats    = 70; // beats over all tests below
	localparam int timeoutCycles = totalBeats * 10 + 1000;

	logic clk;
	logic rstN;
	logic cmdValid;
	addrT cmdBase;
	lenT  cmdLenM1;
	logic cmdReady;
	logic outValid;
	addrT outAddr;
	logic outLast;
	logic creditReturn;

	logic creditHold;  // downstream keeps its credits while set
	addrT monAddr[$];  // every beat seen, in order
	logic monLast[$];
	int   dueCycle[$]; // cycle at which each spent credit comes back
	int   cycleCount;
	int   errorCount;
	int   testErrors;  // errorCount when the current test began
	int   testsRun;
	int   testsBad;

	burstGen u_dut (
		.clk(clk),
		.rstN(rstN),
		.cmdValid(cmdValid),
		.cmdBase(cmdBase),
		.cmdLenM1(cmdLenM1),
		.cmdReady(cmdReady),
		.outValid(outValid),
		.outAddr(outAddr),
		.outLast(outLast),
		.creditReturn(creditReturn)
	);

	always #2 clk = ~clk; // 4 ns period

	// beat monitor plus downstream credit model, all on the falling edge
	initial begin
		void'($urandom(32'h513d_8424)); // random credit delays come from here
		forever begin
			@(negedge clk);
			if (rstN && outValid) begin
				monAddr.push_back(outAddr);
				monLast.push_back(outLast);
				dueCycle.push_back(cycleCount + int'($urandom % 4)); // 0 to 3 cycles later
			end
			if (!creditHold && dueCycle.size() > 0 && dueCycle[0] <= cycleCount) begin
				void'(dueCycle.pop_front());
				creditReturn = 1'b1; // one slot per pulse
			end else begin
				creditReturn = 1'b0;
			end
			cycleCount++;
		end
	end

	initial begin
		repeat (timeoutCycles) @(posedge clk);
		$display("timeout: the run did not finish within %0d cycles", timeoutCycles);
		$display("tests failed");
		$finish;
	end

	task automatic noteFailure(input string msg);
		errorCount++;
		$display("failure at %0t: %s", $time, msg);
	endtask

	task automatic checkAddr(input string name, input addrT expected, input addrT actual);
		if (actual !== expected) begin
			errorCount++;
			$display("error at %0t: %s expected %h got %h", $time, name, expected, actual);
		end
	endtask

	task automatic checkFlag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			errorCount++;
			$display("error at %0t: %s expected %b got %b", $time, name, expected, actual);
		end
	endtask

	task automatic beginTest();
		testErrors = errorCount;
	endtask

	task automatic endTest(input string name);
		testsRun++;
		if (errorCount == testErrors) begin
			$display("test %s: ok", name);
		end else begin
			testsBad++;
			$display("test %s: %0d errors", name, errorCount - testErrors);
		end
	endtask

	// called on a falling edge, returns on the falling edge after the handshake
	task automatic sendCmd(input addrT base, input lenT lenM1);
		cmdValid = 1'b1;
		cmdBase  = base;
		cmdLenM1 = lenM1;
		while (!cmdReady) @(negedge clk);
		@(negedge clk); // accepted on the rising edge in between
	endtask

	// beats counted on rising edges, cmdReady looked at on falling ones
	task automatic waitDone(input int start, input int nBeats);
		while (monAddr.size() < start + nBeats) @(posedge clk);
		@(negedge clk);
		while (!cmdReady) @(negedge clk);
		if (monAddr.size() != start + nBeats) begin
			noteFailure($sformatf("expected %0d beats but saw %0d", nBeats,
				monAddr.size() - start));
		end
	endtask

	// beat k carries base-k mod 2^16, last flag only on beat lenM1
	task automatic compareBurst(input int start, input addrT base, input lenT lenM1);
		for (int k = 0; k <= int'(lenM1); k++) begin
			checkAddr($sformatf("outAddr[beat %0d]", k), addrT'(base - k), monAddr[start + k]);
			checkFlag($sformatf("outLast[beat %0d]", k), k == int'(lenM1), monLast[start + k]);
		end
	endtask

	task automatic afterReset();
		int start;
		beginTest();
		checkFlag("cmdReady", 1'b1, cmdReady);
		checkFlag("outValid", 1'b0, outValid);
		creditHold = 1'b1; // nothing comes back, so only the reset pool
		start = monAddr.size();
		sendCmd(16'h1000, 8'd7);
		cmdValid = 1'b0;
		repeat (20) @(posedge clk);
		if (monAddr.size() - start != `burstCredits) begin
			noteFailure($sformatf("%0d beats went out on %0d reset credits",
				monAddr.size() - start, `burstCredits));
		end
		creditHold = 1'b0;
		waitDone(start, 8);
		compareBurst(start, 16'h1000, 8'd7);
		endTest("after reset");
	endtask

	task automatic singleBeat();
		int start;
		beginTest();
		start = monAddr.size();
		sendCmd(16'h00a5, 8'd0);
		cmdValid = 1'b0;
		waitDone(start, 1);
		compareBurst(start, 16'h00a5, 8'd0);
		sendCmd(16'h0000, 8'd0); // second one proves cmdReady came back
		cmdValid = 1'b0;
		waitDone(start + 1, 1);
		compareBurst(start + 1, 16'h0000, 8'd0);
		endTest("single beat");
	endtask

	task automatic runBurst(input string name, input addrT base, input lenT lenM1);
		int start;
		beginTest();
		start = monAddr.size();
		sendCmd(base, lenM1);
		cmdValid = 1'b0;
		waitDone(start, int'(lenM1) + 1);
		compareBurst(start, base, lenM1);
		endTest(name);
	endtask

	task automatic creditStarve();
		int start;
		int midCount;
		beginTest();
		start = monAddr.size();
		sendCmd(16'h8010, 8'd15);
		cmdValid = 1'b0;
		while (monAddr.size() < start + 3) @(posedge clk);
		creditHold = 1'b1; // the monitor only reads it on falling edges
		repeat (8) @(posedge clk); // credits in hand are gone by now
		midCount = monAddr.size();
		repeat (4) @(posedge clk);
		if (monAddr.size() != midCount) begin
			noteFailure("beats kept coming while credits were withheld");
		end
		creditHold = 1'b0;
		waitDone(start, 16);
		compareBurst(start, 16'h8010, 8'd15);
		endTest("credit starvation");
	endtask

	task automatic backToBack();
		addrT bases[6];
		lenT  lens[6];
		int   start;
		int   offset;
		int   total;
		beginTest();
		bases = '{16'h2000, 16'h0001, 16'hfff0, 16'h0100, 16'h7777, 16'h0002};
		lens  = '{8'd2, 8'd0, 8'd5, 8'd1, 8'd3, 8'd0};
		total = 0;
		foreach (lens[i]) total += int'(lens[i]) + 1;
		start = monAddr.size();
		foreach (bases[i]) sendCmd(bases[i], lens[i]); // valid stays high between
		cmdValid = 1'b0;
		waitDone(start, total);
		offset = start;
		foreach (bases[i]) begin
			compareBurst(offset, bases[i], lens[i]);
			offset += int'(lens[i]) + 1;
		end
		endTest("back to back");
	endtask

	initial begin
		clk          = 1'b0;
		rstN         = 1'b0;
		cmdValid     = 1'b0;
		cmdBase      = '0;
		cmdLenM1     = '0;
		creditReturn = 1'b0;
		creditHold   = 1'b0;
		cycleCount   = 0;
		errorCount   = 0;
		testsRun     = 0;
		testsBad     = 0;
		repeat (3) @(negedge clk); // reset for 3 cycles
		rstN = 1'b1;
		@(negedge clk);

		afterReset();
		singleBeat();
		runBurst("long burst", 16'h4321, 8'd19);
		runBurst("address wrap", 16'h0003, 8'd6);
		creditStarve();
		backToBack();

		$display("tests run %0d, tests with errors %0d, failed checks %0d",
			testsRun, testsBad, errorCount);
		if (errorCount == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// File: burstGen.f
+incdir+logic
logic/burstPkg.sv
logic/PrefixAnd.sv
logic/DecC.sv
logic/BeatTimer.sv
logic/CreditCounter.sv
logic/AddrWalker.sv
logic/BurstFsm.sv
logic/burstGen.sv
tb/tbBurstGen.sv

// File: Bender.yml
package:
  name: burstGen

sources:
  - include_dirs:
      - logic
    files:
      - logic/burstPkg.sv
      - logic/PrefixAnd.sv
      - logic/DecC.sv
      - logic/BeatTimer.sv
      - logic/CreditCounter.sv
      - logic/AddrWalker.sv
      - logic/BurstFsm.sv
      - logic/burstGen.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - tb/tbBurstGen.sv
